/* msx_cart_top.f */
+incdir+include
logic/msx_cart_pkg.sv
logic/boot_timer.sv
logic/bus_sequencer.sv
logic/bus_capture.sv
logic/cart_config.sv
logic/sdc_regs.sv
logic/sector_buffer.sv
logic/bus_responder.sv
logic/msx_cart_top.sv
tests/tb_msx_cart.sv

/* Makefile */
# Verilator simulation of the MSX cartridge bus front end

VERILATOR ?= verilator
TOP       ?= tb_msx_cart
SEED      ?= 1
FILELIST  ?= msx_cart_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ns

.PHONY: sim clean

# the binary exits non-zero on $fatal, so make fails with the test
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD_DIR)

/* include/tb_bus_tasks.svh */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// error handling

task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "stopped at first error");
endtask

task automatic report_timeout(input string what);
    $display("timed out at %0t ns waiting for %s", $time, what);
    stop_with_failure();
endtask

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        stop_with_failure();
    end
endtask

////////////////////////////////////////////////////////////////////////////
// host side of the cartridge bus

// answers the pin mux with the pending cycle, once per clock
task automatic drive_mux();
    @(posedge clk108_w);
    #10;
    case (msel_n)
        MSEL_LOW:  mp = p_addr[7:0];
        MSEL_HIGH: mp = p_addr[15:8];
        MSEL_CTRL: mp = p_ctrl;
        default:   mp = 8'hFF;  // nothing selected
    endcase
endtask

// address and control go up one clock before the strobe
task automatic present_cycle(input cpu_addr_t a, input logic mem_cycle);
    p_addr = a;
    p_ctrl = 8'hFF;
    p_ctrl[CTRL_MERQ] = !mem_cycle;
    p_ctrl[CTRL_IORQ] = mem_cycle;
    p_ctrl[CTRL_M1]   = 1'b1;  // never an M1 cycle here
    @(posedge clk108_w);
    #10;
endtask

// release, then one frame so the synchronised strobes settle
task automatic end_cycle();
    rd_n    = 1'b1;
    wr_n    = 1'b1;
    sltsl_n = 1'b1;
    repeat (SEQ_PERIOD) @(posedge clk108_w);
    #10;
endtask

task automatic bus_write(input cpu_addr_t a, input byte_t d, input logic mem_cycle);
    int n;
    present_cycle(a, mem_cycle);
    cd_in   = d;
    sltsl_n = !mem_cycle;  // slot select on memory cycles only
    wr_n    = 1'b0;
    for (n = 0; n < 3 * SEQ_PERIOD; n++) begin
        @(posedge clk108_w);
        #10;
    end
    end_cycle();
endtask

// memory read in our slot, data one clock after datadir turns
task automatic bus_read(input cpu_addr_t a, output byte_t d);
    int n;
    present_cycle(a, 1'b1);
    sltsl_n = 1'b0;
    rd_n    = 1'b0;
    n = 0;
    while (datadir !== 1'b0 && n < 3 * SEQ_PERIOD) begin
        @(posedge clk108_w);
        #10;
        n++;
    end
    if (datadir !== 1'b0) report_timeout("datadir to go low on a slot read");
    @(posedge clk108_w);
    #10;
    d = cd_out;
    end_cycle();
endtask

`endif

/* tests/tb_msx_cart.sv */
`timescale 1ns/1ns

module tb_msx_cart import msx_cart_pkg::*; ();

    localparam int SEQ_PERIOD = 7;
    localparam int BOOT_LIMIT = int'(BOOT_WARM_CYCLES) + 50;

    logic          clk108_w, ram_enabled_w;
    logic          sltsl_n, rd_n, wr_n;
    byte_t         mp, cd_in, cd_out;
    logic          datadir, wait_n;
    logic [2:0]    msel_n;
    logic          sd_busy, sd_done, sd_crc_error, sd_timeout_error;
    logic [1:0]    sd_card_type;
    logic          sd_rstart, sd_wstart;
    logic [31:0]   sd_sector;
    sector_addr_t  card_addr;
    logic          card_we;
    byte_t         card_wdata, card_rdata;
    megaram_type_t megaram_type;
    logic          scc_enable;
    vol_t          scc_vol, psg_vol, opll_vol;

    cpu_addr_t    p_addr;  // pending host cycle
    byte_t        p_ctrl;
    integer       seed;
    logic         boot_done = 1'b0;
    logic [1:0]   m_type;  // config model
    logic         m_scc;
    vol_t         m_scc_vol, m_psg_vol, m_opll_vol;
    byte_t        buf_model [512];
    sector_addr_t cpu_addrs [$];
    cpu_addr_t    reg_list [4] = '{SDC_ENABLE, SDC_STATUS, SDC_CTYPE, SDC_CMD};

    msx_cart_top u_dut (
        .clk108_w(clk108_w), .ram_enabled_w(ram_enabled_w),
        .sltsl_n(sltsl_n), .rd_n(rd_n), .wr_n(wr_n), .mp(mp),
        .cd_in(cd_in), .cd_out(cd_out), .datadir(datadir), .msel_n(msel_n), .wait_n(wait_n),
        .sd_busy(sd_busy), .sd_done(sd_done), .sd_crc_error(sd_crc_error),
        .sd_timeout_error(sd_timeout_error), .sd_card_type(sd_card_type),
        .sd_rstart(sd_rstart), .sd_wstart(sd_wstart), .sd_sector(sd_sector),
        .card_addr(card_addr), .card_we(card_we), .card_wdata(card_wdata),
        .card_rdata(card_rdata), .megaram_type(megaram_type), .scc_enable(scc_enable),
        .scc_vol(scc_vol), .psg_vol(psg_vol), .opll_vol(opll_vol)
    );

    `include "tb_bus_tasks.svh"

    ////////////////////////////////////////////////////////////////////////////
    // reference models

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    // select code expected on each clock of a frame
    function automatic logic [2:0] seq_model(input int step);
        case (step % SEQ_PERIOD)
            0, 1:    seq_model = MSEL_LOW;
            2, 3:    seq_model = MSEL_HIGH;
            4, 5:    seq_model = MSEL_CTRL;
            default: seq_model = MSEL_NONE;
        endcase
    endfunction

    function automatic void cfg_model(input byte_t d);
        case (d)
            CFG_KONAMI:     m_type = 2'd0;
            CFG_KONAMI_SCC: m_type = 2'd1;
            CFG_ASCII16:    m_type = 2'd2;
            CFG_ASCII8:     m_type = 2'd3;
            default: ;
        endcase
        if (d == CFG_KONAMI || d == CFG_KONAMI_SCC || d == CFG_ASCII16 || d == CFG_ASCII8)
            m_scc = (d == CFG_KONAMI_SCC);
        case (d[7:4])  // attenuation wraps mod 16
            VOL_SCC:  m_scc_vol  = VOL_BASE - d[3:0];
            VOL_PSG:  m_psg_vol  = VOL_BASE - d[3:0];
            VOL_OPLL: m_opll_vol = VOL_BASE - d[3:0];
            default: ;
        endcase
    endfunction

    // mapper code, volume byte or anything
    function automatic byte_t pick_cfg_byte(input logic [31:0] r);
        byte_t codes [4];
        codes = '{CFG_KONAMI, CFG_KONAMI_SCC, CFG_ASCII16, CFG_ASCII8};
        case (r[9:8])
            2'd0:    pick_cfg_byte = codes[r[1:0]];
            2'd1:    pick_cfg_byte = {(r[5:4] == 2'd0) ? VOL_SCC
                                      : (r[5:4] == 2'd1) ? VOL_PSG : VOL_OPLL, r[3:0]};
            default: pick_cfg_byte = r[7:0];
        endcase
    endfunction

    function automatic byte_t sdc_read_model(input cpu_addr_t a, input logic en);
        byte_t r;
        r = READ_IDLE;  // window closed or unmapped
        if (en) begin
            case (a)
                SDC_ENABLE: r = 8'h01;
                SDC_STATUS: r = {sd_busy, 5'b0, sd_timeout_error, sd_crc_error};
                SDC_CTYPE:  r = {6'b0, sd_card_type};
                default:    r = READ_IDLE;
            endcase
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // clock, mux pins, boot monitor

    initial begin
        clk108_w = 1'b0;
        forever #50 clk108_w = ~clk108_w;
    end

    initial begin
        mp = 8'hFF;
        forever drive_mux();
    end

    initial begin
        forever begin
            @(posedge clk108_w);
            #10;
            if (boot_done) check_value(32'(wait_n), 32'd1, "wait_n after boot release");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ordered checks

    initial begin
        int n;
        logic [31:0] rnd, exp_sector;
        byte_t bd, rd_data;
        sector_addr_t ba;
        seed = 32'h39b07f91;
        ram_enabled_w = 1'b0;
        sltsl_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        cd_in = 8'h00;
        {sd_busy, sd_done, sd_crc_error, sd_timeout_error} = 4'b0;
        sd_card_type = 2'b0;
        card_addr = '0;
        card_we = 1'b0;
        card_wdata = 8'h00;
        p_addr = '0;
        p_ctrl = 8'hFF;
        m_type = 2'd1;
        m_scc = 1'b1;
        {m_scc_vol, m_psg_vol, m_opll_vol} = '0;
        repeat (2) @(posedge clk108_w);
        #10;
        check_value(32'(wait_n), 32'd0, "wait_n in reset");
        check_value(32'(datadir), 32'd1, "datadir in reset");
        check_value(32'(msel_n), 32'(MSEL_NONE), "msel_n in reset");
        ram_enabled_w = 1'b1;

        n = 0;
        while (wait_n !== 1'b1 && n < BOOT_LIMIT) begin
            @(posedge clk108_w);
            #10;
            n++;
        end
        if (wait_n !== 1'b1) report_timeout("wait_n release after boot");
        boot_done = 1'b1;

        // frame walk, starting from the idle step
        n = 0;
        while (msel_n !== MSEL_NONE && n <= SEQ_PERIOD) begin
            @(posedge clk108_w);
            #10;
            n++;
        end
        if (msel_n !== MSEL_NONE) report_timeout("msel_n to reach the idle code");
        for (n = 0; n < 3 * SEQ_PERIOD; n++) begin
            @(posedge clk108_w);
            #10;
            check_value(32'(msel_n), 32'(seq_model(n)), "msel_n step");
        end

        for (n = 0; n < 40; n++) begin
            rnd = next_rand();
            bd = pick_cfg_byte(rnd);
            cfg_model(bd);
            bus_write({rnd[23:16], CFG_PORT}, bd, 1'b0);
            check_value(32'(megaram_type), 32'(m_type), "megaram_type");
            check_value(32'(scc_enable), 32'(m_scc), "scc_enable");
            check_value(32'(scc_vol), 32'(m_scc_vol), "scc_vol");
            check_value(32'(psg_vol), 32'(m_psg_vol), "psg_vol");
            check_value(32'(opll_vol), 32'(m_opll_vol), "opll_vol");
        end

        // sd register window
        bus_read(SDC_STATUS, rd_data);
        check_value(32'(rd_data), 32'(sdc_read_model(SDC_STATUS, 1'b0)), "status, window closed");
        bus_write(SDC_ENABLE, 8'h01, 1'b1);
        for (n = 0; n < 4; n++) begin
            rnd = next_rand();
            exp_sector[8*n +: 8] = rnd[7:0];
            bus_write(SDC_SADDR + 16'(n), rnd[7:0], 1'b1);
        end
        check_value(sd_sector, exp_sector, "sd_sector");
        bus_write(SDC_CMD, 8'h03, 1'b1);
        check_value(32'({sd_rstart, sd_wstart}), 32'd3, "start requests");
        sd_done = 1'b1;
        @(posedge clk108_w);
        #10;
        sd_done = 1'b0;
        check_value(32'({sd_rstart, sd_wstart}), 32'd0, "start requests after sd_done");
        for (n = 0; n < 16; n++) begin
            rnd = next_rand();
            {sd_busy, sd_crc_error, sd_timeout_error} = rnd[2:0];
            sd_card_type = rnd[5:4];
            bus_read(reg_list[n % 4], rd_data);
            check_value(32'(rd_data), 32'(sdc_read_model(reg_list[n % 4], 1'b1)),
                        "register readback");
        end

        // sector buffer, cpu side then card side
        for (n = 0; n < 12; n++) begin
            rnd = next_rand();
            ba = rnd[8:0];
            buf_model[ba] = rnd[23:16];
            cpu_addrs.push_back(ba);
            bus_write(SDC_SDATA + {7'b0, ba}, rnd[23:16], 1'b1);
        end
        foreach (cpu_addrs[k]) begin
            bus_read(SDC_SDATA + {7'b0, cpu_addrs[k]}, rd_data);
            check_value(32'(rd_data), 32'(buf_model[cpu_addrs[k]]), "cpu buffer readback");
        end
        for (n = 0; n < 6; n++) begin
            rnd = next_rand();
            ba = rnd[8:0];
            buf_model[ba] = rnd[31:24];
            card_addr = ba;
            card_wdata = rnd[31:24];
            card_we = 1'b1;
            @(posedge clk108_w);
            #10;
            card_we = 1'b0;
            bus_read(SDC_SDATA + {7'b0, ba}, rd_data);
            check_value(32'(rd_data), 32'(buf_model[ba]), "cpu read of card write");
        end
        foreach (cpu_addrs[k]) begin
            card_addr = cpu_addrs[k];
            @(posedge clk108_w);
            #10;
            check_value(32'(card_rdata), 32'(buf_model[cpu_addrs[k]]), "card_rdata");
        end

        // other slot reading, bus must stay turned away
        present_cycle(SDC_STATUS, 1'b1);
        rd_n = 1'b0;
        for (n = 0; n < 3 * SEQ_PERIOD; n++) begin
            @(posedge clk108_w);
            #10;
            check_value(32'(datadir), 32'd1, "datadir with slot not selected");
        end
        end_cycle();

        $display("Test passed");
        $finish;
    end

endmodule

/* logic/msx_cart_top.sv */
`timescale 1ns/1ns

module msx_cart_top import msx_cart_pkg::*; (
    input  logic          clk108_w,
    input  logic          ram_enabled_w,
    input  logic          sltsl_n,
    input  logic          rd_n,
    input  logic          wr_n,
    input  byte_t         mp,
    input  byte_t         cd_in,
    output byte_t         cd_out,
    output logic          datadir,
    output logic [2:0]    msel_n,
    output logic          wait_n,
    input  logic          sd_busy,
    input  logic          sd_done,
    input  logic          sd_crc_error,
    input  logic          sd_timeout_error,
    input  logic [1:0]    sd_card_type,
    output logic          sd_rstart,
    output logic          sd_wstart,
    output logic [31:0]   sd_sector,
    input  sector_addr_t  card_addr,
    input  logic          card_we,
    input  byte_t         card_wdata,
    output byte_t         card_rdata,
    output megaram_type_t megaram_type,
    output logic          scc_enable,
    output vol_t          scc_vol,
    output vol_t          psg_vol,
    output vol_t          opll_vol
);

    logic      sample_en;
    cpu_addr_t addr;
    logic      merq_n, iorq_n, m1_n;
    logic      sltsl_n_s, rd_n_s, wr_n_s;
    byte_t     sdc_rdata, buf_rdata;
    logic      sdc_hit, buf_hit;
    logic      sd_en;

    boot_timer u_boot_timer (
        .clk108_w(clk108_w), .ram_enabled_w(ram_enabled_w), .wait_n(wait_n)
    );

    bus_sequencer u_bus_sequencer (
        .clk108_w(clk108_w), .ram_enabled_w(ram_enabled_w),
        .msel_n(msel_n), .sample_en(sample_en)
    );

    bus_capture u_bus_capture (
        .clk108_w(clk108_w), .ram_enabled_w(ram_enabled_w),
        .mp(mp), .msel_n(msel_n), .sample_en(sample_en),
        .sltsl_n(sltsl_n), .rd_n(rd_n), .wr_n(wr_n),
        .addr(addr), .merq_n(merq_n), .iorq_n(iorq_n), .m1_n(m1_n),
        .sltsl_n_s(sltsl_n_s), .rd_n_s(rd_n_s), .wr_n_s(wr_n_s)
    );

    cart_config u_cart_config (
        .clk108_w(clk108_w), .ram_enabled_w(ram_enabled_w),
        .addr(addr), .cd_in(cd_in), .iorq_n(iorq_n), .m1_n(m1_n), .wr_n_s(wr_n_s),
        .megaram_type(megaram_type), .scc_enable(scc_enable),
        .scc_vol(scc_vol), .psg_vol(psg_vol), .opll_vol(opll_vol)
    );

    sdc_regs u_sdc_regs (
        .clk108_w(clk108_w), .ram_enabled_w(ram_enabled_w),
        .addr(addr), .cd_in(cd_in), .merq_n(merq_n), .iorq_n(iorq_n), .m1_n(m1_n),
        .sltsl_n_s(sltsl_n_s), .rd_n_s(rd_n_s), .wr_n_s(wr_n_s),
        .sd_busy(sd_busy), .sd_done(sd_done), .sd_crc_error(sd_crc_error),
        .sd_timeout_error(sd_timeout_error), .sd_card_type(sd_card_type),
        .sd_rstart(sd_rstart), .sd_wstart(sd_wstart), .sd_sector(sd_sector),
        .sdc_rdata(sdc_rdata), .sdc_hit(sdc_hit), .sd_en(sd_en)
    );

    sector_buffer u_sector_buffer (
        .clk108_w(clk108_w),
        .addr(addr), .cd_in(cd_in), .merq_n(merq_n), .iorq_n(iorq_n),
        .sltsl_n_s(sltsl_n_s), .rd_n_s(rd_n_s), .wr_n_s(wr_n_s), .sd_en(sd_en),
        .card_addr(card_addr), .card_we(card_we), .card_wdata(card_wdata),
        .card_rdata(card_rdata), .buf_rdata(buf_rdata), .buf_hit(buf_hit)
    );

    bus_responder u_bus_responder (
        .clk108_w(clk108_w), .ram_enabled_w(ram_enabled_w),
        .sltsl_n_s(sltsl_n_s), .rd_n_s(rd_n_s),
        .sdc_rdata(sdc_rdata), .sdc_hit(sdc_hit),
        .buf_rdata(buf_rdata), .buf_hit(buf_hit),
        .cd_out(cd_out), .datadir(datadir)
    );

endmodule

/* logic/bus_responder.sv */
`timescale 1ns/1ns

module bus_responder import msx_cart_pkg::*; (
    input  logic  clk108_w,
    input  logic  ram_enabled_w,
    input  logic  sltsl_n_s,
    input  logic  rd_n_s,
    input  byte_t sdc_rdata,
    input  logic  sdc_hit,
    input  byte_t buf_rdata,
    input  logic  buf_hit,
    output byte_t cd_out,
    output logic  datadir
);

    // cartridge drives cd only for its own slot reads
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            datadir <= 1'b1;
        end else begin
            datadir <= !(!sltsl_n_s && !rd_n_s);
        end
    end

    always_ff @(posedge clk108_w) begin
        if (buf_hit)      cd_out <= buf_rdata;
        else if (sdc_hit) cd_out <= sdc_rdata;
        else              cd_out <= READ_IDLE;  // open bus
    end

    // the two windows never overlap
    a_one_source: assert property (
        @(posedge clk108_w) disable iff (!ram_enabled_w)
        !(sdc_hit && buf_hit)
    ) else $error("register and buffer both claim the read");

endmodule

/* logic/sector_buffer.sv */
`timescale 1ns/1ns

module sector_buffer import msx_cart_pkg::*; (
    input  logic         clk108_w,
    input  cpu_addr_t    addr,
    input  byte_t        cd_in,
    input  logic         merq_n,
    input  logic         iorq_n,
    input  logic         sltsl_n_s,
    input  logic         rd_n_s,
    input  logic         wr_n_s,
    input  logic         sd_en,
    input  sector_addr_t card_addr,
    input  logic         card_we,
    input  byte_t        card_wdata,
    output byte_t        card_rdata,
    output byte_t        buf_rdata,
    output logic         buf_hit
);

    byte_t mem [2**SECTOR_AW];
    logic  cpu_cs;

    assign cpu_cs = sd_en && !sltsl_n_s && !merq_n && iorq_n
                  && addr >= SDC_SDATA && addr <= SDC_SDATA_END;

    // both ports on clk108_w, card side wins a same-address collision
    always_ff @(posedge clk108_w) begin
        if (cpu_cs && !wr_n_s) mem[addr[SECTOR_AW-1:0]] <= cd_in;
        if (card_we)           mem[card_addr] <= card_wdata;
        buf_rdata  <= mem[addr[SECTOR_AW-1:0]];
        card_rdata <= mem[card_addr];
        buf_hit    <= cpu_cs && !rd_n_s;  // lines up with buf_rdata
    end

endmodule

/* logic/sdc_regs.sv */
`timescale 1ns/1ns

module sdc_regs import msx_cart_pkg::*; (
    input  logic        clk108_w,
    input  logic        ram_enabled_w,
    input  cpu_addr_t   addr,
    input  byte_t       cd_in,
    input  logic        merq_n,
    input  logic        iorq_n,
    input  logic        m1_n,
    input  logic        sltsl_n_s,
    input  logic        rd_n_s,
    input  logic        wr_n_s,
    input  logic        sd_busy,
    input  logic        sd_done,
    input  logic        sd_crc_error,
    input  logic        sd_timeout_error,
    input  logic [1:0]  sd_card_type,
    output logic        sd_rstart,
    output logic        sd_wstart,
    output logic [31:0] sd_sector,
    output byte_t       sdc_rdata,
    output logic        sdc_hit,
    output logic        sd_en
);

    logic en_wr, sd_cs;

    // the enable register is reachable even while the window is closed
    assign en_wr = !sltsl_n_s && iorq_n && !wr_n_s && addr == SDC_ENABLE;
    assign sd_cs = sd_en && !sltsl_n_s && !merq_n && iorq_n && m1_n
                 && addr >= SDC_ENABLE && addr <= SDC_END;

    ////////////////////////////////////////////////////////////////////////////
    // control
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            sd_en     <= 1'b0;
            sd_rstart <= 1'b0;
            sd_wstart <= 1'b0;
            sdc_hit   <= 1'b0;
        end else begin
            if (en_wr) sd_en <= cd_in[0];
            if (sd_cs && !wr_n_s && addr == SDC_CMD) begin
                sd_rstart <= sd_rstart | cd_in[0];
                sd_wstart <= sd_wstart | cd_in[1];
            end
            if (sd_done) begin  // card engine finished, drop both requests
                sd_rstart <= 1'b0;
                sd_wstart <= 1'b0;
            end
            sdc_hit <= sd_cs && !rd_n_s;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // sector number and readback
    always_ff @(posedge clk108_w) begin
        if (sd_cs && !wr_n_s) begin
            case (addr)
                SDC_SADDR:          sd_sector[7:0]   <= cd_in;
                SDC_SADDR + 16'd1:  sd_sector[15:8]  <= cd_in;
                SDC_SADDR + 16'd2:  sd_sector[23:16] <= cd_in;
                SDC_SADDR + 16'd3:  sd_sector[31:24] <= cd_in;
                default: ;
            endcase
        end
        if (sd_cs && !rd_n_s) begin
            case (addr)
                SDC_ENABLE: sdc_rdata <= {7'b0, sd_en};
                SDC_STATUS: sdc_rdata <= {sd_busy, 5'b0, sd_timeout_error, sd_crc_error};
                SDC_CTYPE:  sdc_rdata <= {6'b0, sd_card_type};
                default:    sdc_rdata <= READ_IDLE;
            endcase
        end
    end

    a_done_clears_start: assert property (
        @(posedge clk108_w) disable iff (!ram_enabled_w)
        sd_done |=> (!sd_rstart && !sd_wstart)
    ) else $error("sd start request survived sd_done");

endmodule

/* logic/cart_config.sv */
`timescale 1ns/1ns

module cart_config import msx_cart_pkg::*; (
    input  logic          clk108_w,
    input  logic          ram_enabled_w,
    input  cpu_addr_t     addr,
    input  byte_t         cd_in,
    input  logic          iorq_n,
    input  logic          m1_n,
    input  logic          wr_n_s,
    output megaram_type_t megaram_type,
    output logic          scc_enable,
    output vol_t          scc_vol,
    output vol_t          psg_vol,
    output vol_t          opll_vol
);

    logic cfg_wr;

    // i/o write to 8Fh, not an interrupt acknowledge
    assign cfg_wr = !iorq_n && m1_n && !wr_n_s && addr[7:0] == CFG_PORT;

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            megaram_type <= KONAMI_SCC;
            scc_enable   <= 1'b1;
            scc_vol      <= '0;
            psg_vol      <= '0;
            opll_vol     <= '0;
        end else if (cfg_wr) begin
            case (cd_in)
                CFG_KONAMI:     begin megaram_type <= KONAMI;     scc_enable <= 1'b0; end
                CFG_KONAMI_SCC: begin megaram_type <= KONAMI_SCC; scc_enable <= 1'b1; end
                CFG_ASCII16:    begin megaram_type <= ASCII16;    scc_enable <= 1'b0; end
                CFG_ASCII8:     begin megaram_type <= ASCII8;     scc_enable <= 1'b0; end
                default: ;
            endcase
            case (cd_in[7:4])  // attenuation, wraps mod 16
                VOL_SCC:  scc_vol  <= VOL_BASE - cd_in[3:0];
                VOL_PSG:  psg_vol  <= VOL_BASE - cd_in[3:0];
                VOL_OPLL: opll_vol <= VOL_BASE - cd_in[3:0];
                default: ;
            endcase
        end
    end

endmodule

/* logic/bus_capture.sv */
`timescale 1ns/1ns

module bus_capture import msx_cart_pkg::*; (
    input  logic       clk108_w,
    input  logic       ram_enabled_w,
    input  byte_t      mp,
    input  logic [2:0] msel_n,
    input  logic       sample_en,
    input  logic       sltsl_n,
    input  logic       rd_n,
    input  logic       wr_n,
    output cpu_addr_t  addr,
    output logic       merq_n,
    output logic       iorq_n,
    output logic       m1_n,
    output logic       sltsl_n_s,
    output logic       rd_n_s,
    output logic       wr_n_s
);

    logic [2:0] strb_meta, strb_sync;  // {sltsl_n, rd_n, wr_n}
    byte_t      lo_stage, hi_stage;
    logic       lo_live;    // strobe was active when the low byte was taken
    logic       cyc_valid;  // address and control belong to the current cycle
    logic       strb_active;

    assign strb_active = !strb_sync[1] || !strb_sync[0];

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            strb_meta <= '1;
            strb_sync <= '1;
        end else begin
            strb_meta <= {sltsl_n, rd_n, wr_n};
            strb_sync <= strb_meta;
        end
    end

    // address bytes wait in staging until the control byte of the same frame
    always_ff @(posedge clk108_w) begin
        if (sample_en && msel_n == MSEL_LOW)  lo_stage <= mp;
        if (sample_en && msel_n == MSEL_HIGH) hi_stage <= mp;
        if (sample_en && msel_n == MSEL_CTRL) addr <= {hi_stage, lo_stage};
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            merq_n    <= 1'b1;
            iorq_n    <= 1'b1;
            m1_n      <= 1'b1;
            lo_live   <= 1'b0;
            cyc_valid <= 1'b0;
        end else begin
            if (sample_en && msel_n == MSEL_LOW) lo_live <= strb_active;
            if (sample_en && msel_n == MSEL_CTRL) begin
                merq_n    <= mp[CTRL_MERQ];
                iorq_n    <= mp[CTRL_IORQ];
                m1_n      <= mp[CTRL_M1];
                cyc_valid <= lo_live && strb_active;
            end
            if (!strb_active) cyc_valid <= 1'b0;  // cycle over
        end
    end

    assign sltsl_n_s = strb_sync[2];
    assign rd_n_s    = strb_sync[1] || !cyc_valid;  // held off until a full frame
    assign wr_n_s    = strb_sync[0] || !cyc_valid;

endmodule

/* logic/bus_sequencer.sv */
`timescale 1ns/1ns

module bus_sequencer import msx_cart_pkg::*; (
    input  logic       clk108_w,
    input  logic       ram_enabled_w,
    output logic [2:0] msel_n,
    output logic       sample_en
);

    seq_state_t state;

    // select code goes out one step, mp is sampled on the next
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            state     <= LOW_SET;
            msel_n    <= MSEL_NONE;
            sample_en <= 1'b0;
        end else begin
            case (state)
                LOW_SET: begin
                    msel_n    <= MSEL_LOW;
                    sample_en <= 1'b0;
                    state     <= LOW_SAMPLE;
                end
                LOW_SAMPLE: begin
                    sample_en <= 1'b1;
                    state     <= HIGH_SET;
                end
                HIGH_SET: begin
                    msel_n    <= MSEL_HIGH;
                    sample_en <= 1'b0;
                    state     <= HIGH_SAMPLE;
                end
                HIGH_SAMPLE: begin
                    sample_en <= 1'b1;
                    state     <= CTRL_SET;
                end
                CTRL_SET: begin
                    msel_n    <= MSEL_CTRL;  // control byte
                    sample_en <= 1'b0;
                    state     <= CTRL_SAMPLE;
                end
                CTRL_SAMPLE: begin
                    sample_en <= 1'b1;
                    state     <= IDLE;
                end
                default: begin
                    msel_n    <= MSEL_NONE;  // pins released
                    sample_en <= 1'b0;
                    state     <= LOW_SET;
                end
            endcase
        end
    end

    a_no_sample_when_idle: assert property (
        @(posedge clk108_w) disable iff (!ram_enabled_w)
        sample_en |-> (msel_n != MSEL_NONE)
    ) else $error("sample strobe with no mux source selected");

endmodule

/* logic/boot_timer.sv */
`timescale 1ns/1ns

module boot_timer import msx_cart_pkg::*; (
    input  logic clk108_w,
    input  logic ram_enabled_w,
    output logic wait_n
);

    logic [31:0] boot_cnt;

    // counts once from reset, then parks at the warm-boot value
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            boot_cnt <= '0;
            wait_n   <= 1'b0;  // cpu held off
        end else begin
            if (boot_cnt != BOOT_WARM_CYCLES) begin
                boot_cnt <= boot_cnt + 32'd1;
            end else begin
                wait_n <= 1'b1;
            end
        end
    end

    // once released the cpu is never stalled again
    a_wait_stays_high: assert property (
        @(posedge clk108_w) disable iff (!ram_enabled_w)
        wait_n |=> wait_n
    ) else $error("wait_n fell after boot release");

endmodule

/* logic/msx_cart_pkg.sv */
package msx_cart_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // cpu side
    localparam int ADDR_W = 16;

    typedef logic [7:0]        byte_t;
    typedef logic [ADDR_W-1:0] cpu_addr_t;

    // pin mux walk, one step per clock
    typedef enum logic [2:0] {
        LOW_SET, LOW_SAMPLE, HIGH_SET, HIGH_SAMPLE, CTRL_SET, CTRL_SAMPLE, IDLE
    } seq_state_t;

    localparam logic [2:0] MSEL_LOW  = 3'b110;  // A0-A7
    localparam logic [2:0] MSEL_HIGH = 3'b101;  // A8-A15
    localparam logic [2:0] MSEL_CTRL = 3'b011;  // merq, iorq .. m1
    localparam logic [2:0] MSEL_NONE = 3'b111;

    // bit positions on mp during the control step
    localparam int CTRL_MERQ = 0;
    localparam int CTRL_IORQ = 1;
    localparam int CTRL_M1   = 7;

    localparam logic [31:0] BOOT_WARM_CYCLES = 32'd400;

    ////////////////////////////////////////////////////////////////////////////
    // config port 8Fh
    localparam byte_t CFG_PORT       = 8'h8F;
    localparam byte_t CFG_KONAMI     = 8'h04;
    localparam byte_t CFG_KONAMI_SCC = 8'h05;
    localparam byte_t CFG_ASCII16    = 8'h16;
    localparam byte_t CFG_ASCII8     = 8'h08;

    localparam logic [3:0] VOL_SCC  = 4'hF;
    localparam logic [3:0] VOL_PSG  = 4'hE;
    localparam logic [3:0] VOL_OPLL = 4'hD;
    localparam logic [3:0] VOL_BASE = 4'd9;

    typedef enum logic [1:0] {KONAMI, KONAMI_SCC, ASCII16, ASCII8} megaram_type_t;
    typedef logic [3:0] vol_t;

    ////////////////////////////////////////////////////////////////////////////
    // sd card window
    localparam cpu_addr_t SDC_SDATA     = 16'h7C00;
    localparam cpu_addr_t SDC_SDATA_END = 16'h7DFF;
    localparam cpu_addr_t SDC_ENABLE    = 16'h7E00;
    localparam cpu_addr_t SDC_CMD       = 16'h7E01;
    localparam cpu_addr_t SDC_STATUS    = 16'h7E02;
    localparam cpu_addr_t SDC_SADDR     = 16'h7E03;  // 4 bytes, lsb first
    localparam cpu_addr_t SDC_CTYPE     = 16'h7E0F;
    localparam cpu_addr_t SDC_END       = 16'h7EFF;

    localparam int SECTOR_AW = 9;
    typedef logic [SECTOR_AW-1:0] sector_addr_t;

    localparam byte_t READ_IDLE = 8'hFF;

endpackage
